/* Bender.yml */
package:
  name: spectrum_peripheral

export_include_dirs:
  - .

sources:
  - ap_types_pkg.sv
  - ap_regs_pkg.sv
  - magnitude.sv
  - band_accum.sv
  - ap_wb_regs.sv
  - spectrum_top.sv
  - target: simulation
    files:
      - tb_spectrum.sv

/* ap_cfg.svh */
// spectrum peripheral sizing
`ifndef AP_CFG_SVH
`define AP_CFG_SVH

// --------------------
// datapath widths
// --------------------
`define AP_SAMPLE_W 16             // one fft component, signed
`define AP_MAG_W 16                // floor sqrt result
`define AP_ENERGY_W 32             // band sum, 256 x 16 bit fits easily
`define AP_WB_W 32                 // wishbone data and address width

// --------------------
// frame and band layout
// --------------------
`define AP_N_BANDS 4               // coarse mel style bands
`define AP_BIN_IDX_W 8             // up to 256 bins per frame

// --------------------
// magnitude pipeline
// --------------------
// 1 square stage, 1 add stage, then the root stages
`define AP_SQRT_BITS_PER_STAGE 4
`define AP_MAG_LATENCY 6           // must equal 2 + AP_MAG_W / AP_SQRT_BITS_PER_STAGE

`endif

/* ap_regs_pkg.sv */
// spectrum register map

package ap_regs_pkg;

    // --------------------
    // word offsets, taken from adr[5:2]
    // --------------------
    typedef enum logic [3:0] {
        REG_CTRL       = 4'h0,   // 0x00 wo
        REG_STATUS     = 4'h1,   // 0x04 ro
        REG_BIN_DATA   = 4'h2,   // 0x08 wo, one bin per write
        REG_MAG_LAST   = 4'h3,   // 0x0c ro
        REG_BAND_EDGE0 = 4'h4,   // 0x10 rw
        REG_BAND_EDGE1 = 4'h5,
        REG_BAND_EDGE2 = 4'h6,
        REG_BAND_EDGE3 = 4'h7,   // 0x1c
        REG_BAND_SUM0  = 4'h8,   // 0x20 ro
        REG_BAND_SUM1  = 4'h9,
        REG_BAND_SUM2  = 4'ha,
        REG_BAND_SUM3  = 4'hb    // 0x2c
    } reg_addr_e;

    // --------------------
    // bit positions
    // --------------------
    localparam int CTRL_CLEAR_BIT = 0;   // write 1 to start a new frame

    localparam int STAT_BUSY_BIT  = 0;   // pipeline or accumulator active
    localparam int STAT_COUNT_LSB = 8;   // bin count in [15:8]

    // byte address of a register, for the host side
    function automatic logic [31:0] reg_offset(input reg_addr_e r);
        return {26'b0, r, 2'b00};
    endfunction

endpackage

/* ap_types_pkg.sv */
// spectrum datapath types
`include "ap_cfg.svh"

package ap_types_pkg;

    // --------------------
    // fft bin as written by the host
    // --------------------
    // imag sits in the upper half of the bus word
    typedef struct packed {
        logic signed [`AP_SAMPLE_W-1:0] imag_part;
        logic signed [`AP_SAMPLE_W-1:0] real_part;
    } cbin_t;

    // bus side keeps the plain word, the pipeline reads the two halves
    typedef union packed {
        logic [2*`AP_SAMPLE_W-1:0] raw;
        cbin_t                     bin;
    } bin_word_u;

    // --------------------
    // results
    // --------------------
    typedef logic [`AP_MAG_W-1:0] mag_t;            // unsigned magnitude

    typedef logic [`AP_ENERGY_W-1:0] energy_t;      // one band sum

    // position of a bin inside the current frame
    typedef logic [`AP_BIN_IDX_W-1:0] bin_idx_t;

endpackage

/* ap_wb_regs.sv */
// wishbone register file for the spectrum peripheral
`timescale 1ns/1ps
`include "ap_cfg.svh"

module ap_wb_regs (
    input  logic                    clk,
    input  logic                    rst,
    // wishbone classic slave
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`AP_WB_W-1:0]     wb_adr,
    input  logic [`AP_WB_W-1:0]     wb_dat_w,
    input  logic [3:0]              wb_sel,
    output logic [`AP_WB_W-1:0]     wb_dat_r,
    output logic                    wb_ack,
    // to the datapath
    output logic                    bin_valid,
    output ap_types_pkg::bin_word_u bin_word,
    output logic                    clear,
    output ap_types_pkg::bin_idx_t  band_edge [`AP_N_BANDS],
    // from the datapath
    input  logic                    mag_valid,
    input  ap_types_pkg::mag_t      mag,
    input  logic                    mag_busy,
    input  logic                    acc_busy,
    input  ap_types_pkg::energy_t   band_sum  [`AP_N_BANDS],
    input  ap_types_pkg::bin_idx_t  bin_count
);

    localparam int BAND_W = $clog2(`AP_N_BANDS);

    ap_regs_pkg::reg_addr_e addr;
    logic                   mapped;      // nothing decoded above 0x3f
    logic                   req;         // new access this cycle
    logic                   wr_en;
    logic                   edge_wr;
    logic [BAND_W-1:0]      band_idx;    // same slot for edges and sums
    logic [`AP_WB_W-1:0]    status;
    logic [`AP_WB_W-1:0]    rd_data;
    ap_types_pkg::mag_t     mag_last_q;
    ap_types_pkg::mag_t     mag_last;

    // --------------------
    // decode
    // --------------------
    assign addr     = ap_regs_pkg::reg_addr_e'(wb_adr[5:2]);
    assign mapped   = (wb_adr[`AP_WB_W-1:6] == '0);
    assign band_idx = wb_adr[2 +: BAND_W];
    assign req      = wb_cyc && wb_stb && !wb_ack;   // ack is a single cycle
    assign wr_en    = req && wb_we && mapped && (wb_sel != 4'h0);   // sel only gates empty writes
    assign edge_wr  = wr_en
                      && (addr inside {[ap_regs_pkg::REG_BAND_EDGE0:ap_regs_pkg::REG_BAND_EDGE3]});

    // fresh result visible in the cycle it leaves the pipe
    assign mag_last = mag_valid ? mag : mag_last_q;

    always_comb begin
        status = '0;
        status[ap_regs_pkg::STAT_BUSY_BIT] = mag_busy | acc_busy;
        status[ap_regs_pkg::STAT_COUNT_LSB +: `AP_BIN_IDX_W] = bin_count;
    end

    // --------------------
    // readback mux
    // --------------------
    always_comb begin
        rd_data = '0;                    // write only and unmapped read zero
        if (mapped) begin
            case (addr)
                ap_regs_pkg::REG_STATUS:   rd_data = status;
                ap_regs_pkg::REG_MAG_LAST: rd_data = `AP_WB_W'(mag_last);
                ap_regs_pkg::REG_BAND_EDGE0, ap_regs_pkg::REG_BAND_EDGE1,
                ap_regs_pkg::REG_BAND_EDGE2, ap_regs_pkg::REG_BAND_EDGE3:
                    rd_data = `AP_WB_W'(band_edge[band_idx]);
                ap_regs_pkg::REG_BAND_SUM0, ap_regs_pkg::REG_BAND_SUM1,
                ap_regs_pkg::REG_BAND_SUM2, ap_regs_pkg::REG_BAND_SUM3:
                    rd_data = `AP_WB_W'(band_sum[band_idx]);
                default:                   rd_data = '0;
            endcase
        end
    end

    // --------------------
    // bus response and control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            wb_dat_r   <= '0;
            bin_valid  <= 1'b0;
            clear      <= 1'b0;
            mag_last_q <= '0;
            for (int k = 0; k < `AP_N_BANDS; k++) begin
                band_edge[k] <= '0;
            end
        end else begin
            wb_ack    <= req;
            bin_valid <= wr_en && (addr == ap_regs_pkg::REG_BIN_DATA);   // starts the pipe
            clear     <= wr_en && (addr == ap_regs_pkg::REG_CTRL)
                         && wb_dat_w[ap_regs_pkg::CTRL_CLEAR_BIT];
            if (req && !wb_we) begin
                wb_dat_r <= rd_data;
            end
            if (mag_valid) begin
                mag_last_q <= mag;
            end
            if (edge_wr) begin
                band_edge[band_idx] <= wb_dat_w[`AP_BIN_IDX_W-1:0];
            end
        end
    end

    // bin payload, taken as a plain word
    always_ff @(posedge clk) begin
        if (wr_en && (addr == ap_regs_pkg::REG_BIN_DATA)) begin
            bin_word.raw <= wb_dat_w;
        end
    end

    // master holds cyc and stb until it sees ack
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> wb_cyc && wb_stb);

endmodule

/* band_accum.sv */
// band energy accumulator
`timescale 1ns/1ps
`include "ap_cfg.svh"

module band_accum (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   mag_valid,
    input  ap_types_pkg::mag_t     mag,
    input  ap_types_pkg::bin_idx_t band_edge [`AP_N_BANDS],
    output ap_types_pkg::energy_t  band_sum  [`AP_N_BANDS],
    output ap_types_pkg::bin_idx_t bin_count,
    output logic                   acc_busy
);

    localparam int BAND_W = $clog2(`AP_N_BANDS);

    ap_types_pkg::bin_idx_t idx;        // index of the arriving magnitude
    ap_types_pkg::bin_idx_t count_d;
    logic [BAND_W-1:0]      band_sel;
    logic                   band_hit;   // low above the last edge

    // --------------------
    // index of this bin
    // --------------------
    // a bin landing on the clear edge is bin 0 of the new frame
    assign idx = clear ? '0 : bin_count;

    assign count_d = idx + ap_types_pkg::bin_idx_t'(mag_valid);

    // --------------------
    // band lookup
    // --------------------
    // band k covers (edge[k-1], edge[k]], band 0 starts at 0
    always_comb begin
        logic above_prev;
        band_hit   = 1'b0;
        band_sel   = '0;
        above_prev = 1'b1;
        for (int k = 0; k < `AP_N_BANDS; k++) begin
            if (!band_hit && above_prev && (idx <= band_edge[k])) begin
                band_hit = 1'b1;          // first match wins
                band_sel = BAND_W'(k);
            end
            above_prev = idx > band_edge[k];
        end
    end

    // --------------------
    // sums and count
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `AP_N_BANDS; k++) begin
                band_sum[k] <= '0;
            end
            bin_count <= '0;
        end else if (clear || mag_valid) begin
            for (int k = 0; k < `AP_N_BANDS; k++) begin
                if (mag_valid && band_hit && (band_sel == BAND_W'(k))) begin
                    // start from zero when clearing on the same edge
                    band_sum[k] <= (clear ? '0 : band_sum[k])
                                   + ap_types_pkg::energy_t'(mag);
                end else if (clear) begin
                    band_sum[k] <= '0;
                end
            end
            bin_count <= count_d;          // dropped bins still count
        end
    end

    // add lands on the next edge
    assign acc_busy = mag_valid;

    // frame longer than the counter range
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        mag_valid && !clear |=> bin_count != '0);

endmodule

/* list.f */
+incdir+.
ap_types_pkg.sv
ap_regs_pkg.sv
magnitude.sv
band_accum.sv
ap_wb_regs.sv
spectrum_top.sv
tb_spectrum.sv

/* magnitude.sv */
// complex bin magnitude pipeline
`timescale 1ns/1ps
`include "ap_cfg.svh"

module magnitude (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    bin_valid,
    input  ap_types_pkg::bin_word_u bin_word,
    output logic                    mag_valid,
    output ap_types_pkg::mag_t      mag,
    output logic                    mag_busy
);

    localparam int SQRT_STAGES = `AP_MAG_W / `AP_SQRT_BITS_PER_STAGE;
    localparam int RAD_W       = 2 * `AP_MAG_W;   // radicand, sum of squares
    localparam int REM_W       = `AP_MAG_W + 4;   // remainder stays below 2*root+1

    // two's complement abs, -32768 maps to 32768
    function automatic logic [`AP_SAMPLE_W-1:0] abs_val(
        input logic signed [`AP_SAMPLE_W-1:0] x
    );
        logic [`AP_SAMPLE_W-1:0] ux;
        ux = x;
        abs_val = ux[`AP_SAMPLE_W-1] ? (~ux + 1'b1) : ux;
    endfunction

    logic [`AP_SAMPLE_W-1:0] re_abs;
    logic [`AP_SAMPLE_W-1:0] im_abs;

    logic             s1_valid;
    logic [RAD_W-1:0] s1_sq_re;
    logic [RAD_W-1:0] s1_sq_im;
    logic             s2_valid;
    logic [RAD_W-1:0] s2_rad;

    // root stage registers, one entry per stage
    logic                 sq_valid [SQRT_STAGES];
    logic [RAD_W-1:0]     rad_q    [SQRT_STAGES-1];   // radicand bits not yet consumed
    logic [REM_W-1:0]     rem_q    [SQRT_STAGES-1];
    logic [`AP_MAG_W-1:0] root_q   [SQRT_STAGES];

    // --------------------
    // stage 1, abs and square
    // --------------------
    assign re_abs = abs_val(bin_word.bin.real_part);   // same word the bus side stored raw
    assign im_abs = abs_val(bin_word.bin.imag_part);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= bin_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_sq_re <= RAD_W'(re_abs) * RAD_W'(re_abs);
        s1_sq_im <= RAD_W'(im_abs) * RAD_W'(im_abs);
        s2_rad   <= s1_sq_re + s1_sq_im;   // stage 2, at most 2^31
    end

    // --------------------
    // stages 3 to 6, restoring root
    // --------------------
    for (genvar s = 0; s < SQRT_STAGES; s++) begin : g_sqrt
        logic                 vld_in;
        logic [RAD_W-1:0]     rad_in;
        logic [REM_W-1:0]     rem_in;
        logic [`AP_MAG_W-1:0] root_in;
        logic [RAD_W-1:0]     rad_d;
        logic [REM_W-1:0]     rem_d;
        logic [`AP_MAG_W-1:0] root_d;

        if (s == 0) begin : g_first
            assign vld_in  = s2_valid;
            assign rad_in  = s2_rad;
            assign rem_in  = '0;          // fresh remainder and root
            assign root_in = '0;
        end else begin : g_chain
            assign vld_in  = sq_valid[s-1];
            assign rad_in  = rad_q[s-1];
            assign rem_in  = rem_q[s-1];
            assign root_in = root_q[s-1];
        end

        // one root bit per inner step, two radicand bits in from the top
        always_comb begin
            logic [REM_W-1:0] trial;
            rad_d  = rad_in;
            rem_d  = rem_in;
            root_d = root_in;
            for (int b = 0; b < `AP_SQRT_BITS_PER_STAGE; b++) begin
                rem_d = {rem_d[REM_W-3:0], rad_d[RAD_W-1 -: 2]};
                rad_d = rad_d << 2;
                trial = REM_W'({root_d, 2'b01});   // 4*root + 1
                if (rem_d >= trial) begin
                    rem_d  = rem_d - trial;
                    root_d = {root_d[`AP_MAG_W-2:0], 1'b1};
                end else begin
                    root_d = {root_d[`AP_MAG_W-2:0], 1'b0};   // restore, keep remainder
                end
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                sq_valid[s] <= 1'b0;
            end else begin
                sq_valid[s] <= vld_in;
            end
        end

        always_ff @(posedge clk) begin
            root_q[s] <= root_d;
        end

        // last stage hands on only its root
        if (s < SQRT_STAGES - 1) begin : g_carry
            always_ff @(posedge clk) begin
                rad_q[s] <= rad_d;
                rem_q[s] <= rem_d;
            end
        end
    end

    assign mag_valid = sq_valid[SQRT_STAGES-1];
    assign mag       = root_q[SQRT_STAGES-1];

    // any slot occupied
    always_comb begin
        mag_busy = s1_valid | s2_valid;
        for (int s = 0; s < SQRT_STAGES; s++) begin
            mag_busy = mag_busy | sq_valid[s];
        end
    end

    // fixed latency, no stalls anywhere
    a_mag_latency: assert property (@(posedge clk) disable iff (rst)
        bin_valid |-> ##(`AP_MAG_LATENCY) mag_valid);

endmodule

/* spectrum_top.sv */
// spectrum magnitude and band energy peripheral
`timescale 1ns/1ps
`include "ap_cfg.svh"

module spectrum_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [`AP_WB_W-1:0] wb_adr,
    input  logic [`AP_WB_W-1:0] wb_dat_w,
    input  logic [3:0]          wb_sel,
    output logic [`AP_WB_W-1:0] wb_dat_r,
    output logic                wb_ack
);

    // --------------------
    // internal links
    // --------------------
    logic                    bin_valid;
    ap_types_pkg::bin_word_u bin_word;
    logic                    mag_valid;
    ap_types_pkg::mag_t      mag;
    logic                    mag_busy;
    logic                    acc_busy;
    logic                    clear;
    ap_types_pkg::bin_idx_t  band_edge [`AP_N_BANDS];
    ap_types_pkg::energy_t   band_sum  [`AP_N_BANDS];
    ap_types_pkg::bin_idx_t  bin_count;

    // host side, registers and bin injection
    ap_wb_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .bin_valid (bin_valid),
        .bin_word  (bin_word),
        .clear     (clear),
        .band_edge (band_edge),
        .mag_valid (mag_valid),
        .mag       (mag),
        .mag_busy  (mag_busy),
        .acc_busy  (acc_busy),
        .band_sum  (band_sum),
        .bin_count (bin_count)
    );

    magnitude i_mag (
        .clk       (clk),
        .rst       (rst),
        .bin_valid (bin_valid),
        .bin_word  (bin_word),
        .mag_valid (mag_valid),
        .mag       (mag),
        .mag_busy  (mag_busy)
    );

    // one cycle after the magnitude leaves the pipe
    band_accum i_acc (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .mag_valid (mag_valid),
        .mag       (mag),
        .band_edge (band_edge),
        .band_sum  (band_sum),
        .bin_count (bin_count),
        .acc_busy  (acc_busy)
    );

endmodule

/* tb_spectrum.sv */
// spectrum peripheral testbench
`timescale 1ns/1ps
`include "ap_cfg.svh"

module tb_spectrum;

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [`AP_WB_W-1:0] wb_adr;
    logic [`AP_WB_W-1:0] wb_dat_w;
    logic [3:0]          wb_sel;
    logic [`AP_WB_W-1:0] wb_dat_r;
    logic                wb_ack;

    logic [31:0]            lfsr_q;                  // random source state
    ap_types_pkg::bin_idx_t edge_m [`AP_N_BANDS];    // model of the edge registers
    ap_types_pkg::energy_t  sum_m  [`AP_N_BANDS];    // expected band sums
    int                     count_m;                 // expected bin count

    spectrum_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #10 clk = ~clk;   // 20 ns period

    // --------------------
    // failure and compare
    // --------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_mag(input string name, input ap_types_pkg::mag_t got,
                             input ap_types_pkg::mag_t exp);
        if (got !== exp)
            report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_energy(input string name, input ap_types_pkg::energy_t got,
                                input ap_types_pkg::energy_t exp);
        if (got !== exp)
            report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_count(input string name, input ap_types_pkg::bin_idx_t got,
                               input ap_types_pkg::bin_idx_t exp);
        if (got !== exp)
            report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // raw register words, status and readback
    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // --------------------
    // wishbone master
    // --------------------
    task automatic wb_cycle(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n = 0;
        do begin
            @(posedge clk);
            #1;                          // ack and read data settled
            n++;
        end while (!wb_ack && n < 20);
        if (!wb_ack)
            report_failure($sformatf("no wishbone ack within 20 cycles at 0x%h", adr));
        rdata = wb_dat_r;
        @(posedge clk);                  // ack is taken on this edge
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, '0, data);
    endtask

    // poll status until pipeline and accumulator are empty
    task automatic wait_idle();
        logic [31:0] st;
        int n;
        n = 0;
        do begin
            wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_STATUS), st);
            n++;
        end while (st[ap_regs_pkg::STAT_BUSY_BIT] && n < 50);
        if (st[ap_regs_pkg::STAT_BUSY_BIT])
            report_failure("busy stayed high after 50 status polls");
    endtask

    // --------------------
    // random source and model
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois form
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};   // one step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // floor sqrt by bisection, root always below 65536
    function automatic int ref_sqrt(input longint n);
        int lo;
        int hi;
        int mid;
        lo = 0;
        hi = 65536;
        while (hi - lo > 1) begin
            mid = (lo + hi) / 2;
            if (longint'(mid) * mid <= n) lo = mid;
            else hi = mid;
        end
        return lo;
    endfunction

    // first band whose range holds idx, -1 above the last edge
    function automatic int band_of(input int idx);
        for (int k = 0; k < `AP_N_BANDS; k++) begin
            if ((k == 0 || idx > edge_m[k-1]) && idx <= edge_m[k]) return k;
        end
        return -1;
    endfunction

    function automatic void clear_model();
        for (int k = 0; k < `AP_N_BANDS; k++) sum_m[k] = '0;
        count_m = 0;
    endfunction

    // write one bin and account for it in the model
    task automatic push_bin(input int re, input int im, output ap_types_pkg::mag_t exp);
        ap_types_pkg::bin_word_u w;
        int b;
        w.bin.real_part = re[15:0];
        w.bin.imag_part = im[15:0];
        exp = ref_sqrt(longint'(re) * re + longint'(im) * im);
        wb_write(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_BIN_DATA), w.raw);
        b = band_of(count_m);
        if (b >= 0) sum_m[b] += exp;
        count_m++;
    endtask

    task automatic push_random(output ap_types_pkg::mag_t exp);
        logic [31:0] re;
        logic [31:0] im;
        re = take_bits(16);
        im = take_bits(16);
        push_bin(int'($signed(re[15:0])), int'($signed(im[15:0])), exp);
    endtask

    task automatic set_edges(input int e0, input int e1, input int e2, input int e3);
        int e [4];
        e = '{e0, e1, e2, e3};
        for (int k = 0; k < `AP_N_BANDS; k++) begin
            wb_write(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_BAND_EDGE0) + 4 * k, e[k]);
            edge_m[k] = e[k];
        end
    endtask

    task automatic check_sums();
        logic [31:0] rd;
        for (int k = 0; k < `AP_N_BANDS; k++) begin
            wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_BAND_SUM0) + 4 * k, rd);
            check_energy($sformatf("band_sum%0d", k), rd, sum_m[k]);
        end
        wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_STATUS), rd);
        check_count("bin_count", rd[ap_regs_pkg::STAT_COUNT_LSB +: 8], count_m);
    endtask

    task automatic check_mag_last(input ap_types_pkg::mag_t exp);
        logic [31:0] rd;
        wait_idle();
        wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_MAG_LAST), rd);
        check_mag("mag_last", rd[15:0], exp);
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_reset();
        logic [31:0] rd;
        wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_STATUS), rd);
        check_word("status", rd, '0);
        for (int k = 0; k < `AP_N_BANDS; k++) begin
            wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_BAND_EDGE0) + 4 * k, rd);
            check_word($sformatf("band_edge%0d", k), rd, '0);
        end
        check_sums();
    endtask

    task automatic test_mag_corners();
        int re [6];
        int im [6];
        ap_types_pkg::mag_t exp;
        re = '{0, 1234, 0, 3, -32768, -5};
        im = '{0, 0, -777, 4, -32768, 12};   // largest radicand is 2^31
        for (int i = 0; i < 6; i++) begin
            push_bin(re[i], im[i], exp);
            check_mag_last(exp);
        end
    endtask

    task automatic test_mag_random();
        ap_types_pkg::mag_t exp;
        for (int i = 0; i < 40; i++) begin
            push_random(exp);
            check_mag_last(exp);
        end
    endtask

    task automatic test_band_accum();
        ap_types_pkg::mag_t exp;
        set_edges(3, 7, 15, 31);
        wb_write(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_CTRL), 32'h1);
        clear_model();
        for (int i = 0; i < 40; i++) push_random(exp);   // no polling in between
        wait_idle();
        check_sums();                                    // bins 32..39 dropped
    endtask

    task automatic test_clear();
        ap_types_pkg::mag_t exp;
        wb_write(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_CTRL), 32'h1);
        clear_model();
        check_sums();
        for (int i = 0; i < 5; i++) push_random(exp);
        wait_idle();
        check_sums();
    endtask

    task automatic test_corners();
        logic [31:0] rd;
        ap_types_pkg::mag_t exp;
        set_edges(3, 3, 10, 20);                         // band 1 stays empty
        for (int k = 0; k < `AP_N_BANDS; k++) begin
            wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_BAND_EDGE0) + 4 * k, rd);
            check_word($sformatf("band_edge%0d", k), rd, edge_m[k]);
        end
        wb_write(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_CTRL), 32'h1);
        clear_model();
        for (int i = 0; i < 12; i++) push_random(exp);
        wait_idle();
        check_sums();
        // unmapped offsets, aliasing edge0 in the low bits
        wb_write(32'h0000_0050, 32'hff);
        wb_read(ap_regs_pkg::reg_offset(ap_regs_pkg::REG_BAND_EDGE0), rd);
        check_word("band_edge0", rd, edge_m[0]);
        wb_read(32'h0000_0030, rd);
        check_word("unmapped_30", rd, '0);
        wb_read(32'h0000_0100, rd);
        check_word("unmapped_100", rd, '0);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'hf;            // full word only
        lfsr_q   = 32'h7f402500;
        for (int k = 0; k < `AP_N_BANDS; k++) edge_m[k] = '0;
        clear_model();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_mag_corners();
        test_mag_random();
        test_band_accum();
        test_clear();
        test_corners();

        $display("PASS: all tests");
        $finish;
    end

endmodule
